// File: rtl/alu_unit.sv
/* Integer ALU unit */

`timescale 1ns/1ns

module alu_unit (
    inst_bus_if.slave    ibus,
    reg_port_if.master   regs
);

    core_pkg::xlen_t  op_a;
    core_pkg::xlen_t  op_b;
    core_pkg::xlen_t  result;
    logic [4:0]       shamt;

    //////////////////////////////////////////////////////////////////////
    // Operand fetch
    //////////////////////////////////////////////////////////////////////

    assign regs.rs1_addr = ibus.rs1_addr;
    assign regs.rs2_addr = ibus.rs2_addr;

    assign op_a  = regs.rs1_val;
    assign op_b  = ibus.use_imm ? ibus.imm : regs.rs2_val;
    // Shifts only look at the low 5 bits
    assign shamt = op_b[4:0];

    //////////////////////////////////////////////////////////////////////
    // Compute
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ibus.alu_op)
            core_pkg::ALU_ADD:    result = op_a + op_b;
            core_pkg::ALU_SUB:    result = op_a - op_b;
            core_pkg::ALU_SLL:    result = op_a << shamt;
            core_pkg::ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU:   result = {31'b0, op_a < op_b};
            core_pkg::ALU_XOR:    result = op_a ^ op_b;
            core_pkg::ALU_SRL:    result = op_a >> shamt;
            core_pkg::ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
            core_pkg::ALU_OR:     result = op_a | op_b;
            core_pkg::ALU_AND:    result = op_a & op_b;
            // LUI
            core_pkg::ALU_PASS_B: result = op_b;
            default:              result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Writeback, taken by the register file on the issue edge
    //////////////////////////////////////////////////////////////////////

    assign regs.rd_wr   = ibus.valid;
    assign regs.rd_addr = ibus.rd_addr;
    assign regs.rd_val  = result;

endmodule

// File: rtl/core_control.sv
/* Fetch and issue controller */

`timescale 1ns/1ns

module core_control #(
    parameter core_pkg::xlen_t BOOT_ADDR = '0,
    parameter int              RV32E     = 0
) (
    input  logic                            aclk,
    input  logic                            rst_n,
    // Instruction fetch channel
    output logic                            imem_arvalid,
    input  logic                            imem_arready,
    output core_pkg::xlen_t                 imem_araddr,
    input  logic                            imem_rvalid,
    output logic                            imem_rready,
    input  core_pkg::inst_t                 imem_rdata,
    // Status and debug
    output logic [core_pkg::STATUS_W-1:0]   status,
    output core_pkg::xlen_t                 pc,
    // Issue bus to the ALU
    inst_bus_if.master                      ibus
);

    typedef enum logic [1:0] {
        FETCH_REQ,
        FETCH_WAIT,
        EXEC,
        HALT
    } ctrl_state_e;

    ctrl_state_e      state;
    core_pkg::inst_t  instr_q;
    logic             arvalid_q;
    logic             dec_ebreak;
    logic             dec_illegal;

    //////////////////////////////////////////////////////////////////////
    // Decode of the captured word
    //////////////////////////////////////////////////////////////////////

    inst_decoder #(
        .RV32E     (RV32E)
    ) u_decoder (
        .instr     (instr_q),
        .alu_op    (ibus.alu_op),
        .rs1_addr  (ibus.rs1_addr),
        .rs2_addr  (ibus.rs2_addr),
        .rd_addr   (ibus.rd_addr),
        .imm       (ibus.imm),
        .use_imm   (ibus.use_imm),
        .is_ebreak (dec_ebreak),
        .illegal   (dec_illegal)
    );

    // Only plain ALU work goes out to the datapath
    assign ibus.valid = (state == EXEC) && !dec_ebreak && !dec_illegal;

    //////////////////////////////////////////////////////////////////////
    // Fetch handshake
    //////////////////////////////////////////////////////////////////////

    assign imem_arvalid = arvalid_q;
    // Address held on pc until the transfer
    assign imem_araddr  = pc;
    assign imem_rready  = (state == FETCH_WAIT);

    always_ff @(posedge aclk) begin
        if (state == FETCH_WAIT && imem_rvalid) begin
            instr_q <= imem_rdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state     <= FETCH_REQ;
            pc        <= BOOT_ADDR;
            status    <= '0;
            arvalid_q <= 1'b0;
        end else begin
            case (state)
                FETCH_REQ: begin
                    if (arvalid_q && imem_arready) begin
                        arvalid_q <= 1'b0;
                        state     <= FETCH_WAIT;
                    end else begin
                        arvalid_q <= 1'b1;
                    end
                end
                FETCH_WAIT: begin
                    if (imem_rvalid) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (dec_ebreak) begin
                        status[core_pkg::STATUS_EBREAK] <= 1'b1;
                        state                           <= HALT;
                    end else begin
                        if (dec_illegal) begin
                            status[core_pkg::STATUS_ILLEGAL] <= 1'b1;
                        end
                        // Next request starts right away
                        pc        <= pc + 32'd4;
                        arvalid_q <= 1'b1;
                        state     <= FETCH_REQ;
                    end
                end
                HALT: begin
                    // Left only through reset
                    arvalid_q <= 1'b0;
                end
                default: begin
                    state <= FETCH_REQ;
                end
            endcase
        end
    end

endmodule

// File: rtl/core_pkg.sv
/* RV32I core shared definitions */

package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and vector types
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN = 32;
    localparam int ILEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ILEN-1:0] inst_t;
    typedef logic [4:0]      reg_addr_t;

    // Operations executed by the integer ALU
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Opcodes and fixed encodings
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam inst_t EBREAK_WORD = 32'h0010_0073;

    // Status bits
    localparam int STATUS_W       = 2;
    localparam int STATUS_EBREAK  = 0;
    // Sticky once set
    localparam int STATUS_ILLEGAL = 1;

endpackage

// File: rtl/inst_bus_if.sv
/* Decoded instruction bus */

`timescale 1ns/1ns

interface inst_bus_if;

    // One-cycle issue pulse
    logic                  valid;
    core_pkg::alu_op_e     alu_op;
    core_pkg::reg_addr_t   rs1_addr;
    core_pkg::reg_addr_t   rs2_addr;
    core_pkg::reg_addr_t   rd_addr;
    core_pkg::xlen_t       imm;
    // Operand B from imm instead of rs2
    logic                  use_imm;

    modport master (
        output valid, alu_op, rs1_addr, rs2_addr, rd_addr, imm, use_imm
    );

    modport slave (
        input valid, alu_op, rs1_addr, rs2_addr, rd_addr, imm, use_imm
    );

endinterface

// File: rtl/inst_decoder.sv
/* RV32I instruction decoder */

`timescale 1ns/1ns

module inst_decoder #(
    parameter int RV32E = 0
) (
    input  core_pkg::inst_t      instr,
    output core_pkg::alu_op_e    alu_op,
    output core_pkg::reg_addr_t  rs1_addr,
    output core_pkg::reg_addr_t  rs2_addr,
    output core_pkg::reg_addr_t  rd_addr,
    output core_pkg::xlen_t      imm,
    output logic                 use_imm,
    output logic                 is_ebreak,
    output logic                 illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt_ok;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // funct7 of 0100000 only selects SUB and SRA
    assign alt_ok = (funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101);

    function automatic core_pkg::alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        core_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  op = core_pkg::ALU_SLL;
            3'b010:  op = core_pkg::ALU_SLT;
            3'b011:  op = core_pkg::ALU_SLTU;
            3'b100:  op = core_pkg::ALU_XOR;
            3'b101:  op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  op = core_pkg::ALU_OR;
            default: op = core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        alu_op    = core_pkg::ALU_ADD;
        rs1_addr  = instr[19:15];
        rs2_addr  = instr[24:20];
        rd_addr   = instr[11:7];
        // I-type immediate by default
        imm       = {{20{instr[31]}}, instr[31:20]};
        use_imm   = 1'b0;
        is_ebreak = 1'b0;
        illegal   = 1'b0;

        case (opcode)
            core_pkg::OPC_OP: begin
                alu_op  = f3_op(funct3, alt_ok);
                illegal = (funct7 != 7'b0) && !alt_ok;
                if (RV32E != 0 && (rs1_addr[4] || rs2_addr[4] || rd_addr[4])) begin
                    illegal = 1'b1;
                end
            end
            core_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                // No SUBI, upper bits are immediate except for shifts
                alu_op  = f3_op(funct3, alt_ok && funct3 == 3'b101);
                if (funct3 == 3'b001 && funct7 != 7'b0) begin
                    illegal = 1'b1;
                end
                if (funct3 == 3'b101 && funct7 != 7'b0 && !alt_ok) begin
                    illegal = 1'b1;
                end
                if (RV32E != 0 && (rs1_addr[4] || rd_addr[4])) begin
                    illegal = 1'b1;
                end
            end
            core_pkg::OPC_LUI: begin
                alu_op   = core_pkg::ALU_PASS_B;
                rs1_addr = '0;
                imm      = {instr[31:12], 12'b0};
                use_imm  = 1'b1;
                if (RV32E != 0 && rd_addr[4]) begin
                    illegal = 1'b1;
                end
            end
            core_pkg::OPC_SYSTEM: begin
                is_ebreak = (instr == core_pkg::EBREAK_WORD);
                illegal   = (instr != core_pkg::EBREAK_WORD);
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: rtl/isa_registers.sv
/* Integer register file */

`timescale 1ns/1ns

module isa_registers #(
    parameter int RV32E = 0
) (
    input  logic                              aclk,
    input  logic                              rst_n,
    reg_port_if.slave                         port,
    output logic [32*core_pkg::XLEN-1:0]      dbg_regs
);

    localparam int NREGS = (RV32E != 0) ? 16 : 32;
    localparam int AW    = (RV32E != 0) ? 4 : 5;

    core_pkg::xlen_t regs [NREGS];

    // Unimplemented indices read as zero
    assign port.rs1_val = (port.rs1_addr < NREGS) ? regs[port.rs1_addr[AW-1:0]] : '0;
    assign port.rs2_val = (port.rs2_addr < NREGS) ? regs[port.rs2_addr[AW-1:0]] : '0;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (port.rd_wr && port.rd_addr != '0 && port.rd_addr < NREGS) begin
            // x0 never written, stays at its reset value
            regs[port.rd_addr[AW-1:0]] <= port.rd_val;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Flat debug view, x0 in the low word
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < 32; i++) begin : g_dbg
        if (i < NREGS) begin : g_impl
            assign dbg_regs[i*core_pkg::XLEN +: core_pkg::XLEN] = regs[i];
        end else begin : g_none
            assign dbg_regs[i*core_pkg::XLEN +: core_pkg::XLEN] = '0;
        end
    end

endmodule

// File: rtl/reg_port_if.sv
/* Register file access port */

`timescale 1ns/1ns

interface reg_port_if;

    // Read ports, values return combinationally
    core_pkg::reg_addr_t   rs1_addr;
    core_pkg::xlen_t       rs1_val;
    core_pkg::reg_addr_t   rs2_addr;
    core_pkg::xlen_t       rs2_val;

    // Write port
    logic                  rd_wr;
    core_pkg::reg_addr_t   rd_addr;
    core_pkg::xlen_t       rd_val;

    modport master (
        output rs1_addr, rs2_addr, rd_wr, rd_addr, rd_val,
        input  rs1_val, rs2_val
    );

    modport slave (
        input  rs1_addr, rs2_addr, rd_wr, rd_addr, rd_val,
        output rs1_val, rs2_val
    );

endinterface

// File: rtl/rv32i_core.sv
/* RV32I integer core top */

`timescale 1ns/1ns

module rv32i_core #(
    parameter core_pkg::xlen_t BOOT_ADDR = '0,
    parameter int              RV32E     = 0
) (
    input  logic                              aclk,
    input  logic                              rst_n,
    // Instruction fetch channel
    output logic                              imem_arvalid,
    input  logic                              imem_arready,
    output core_pkg::xlen_t                   imem_araddr,
    input  logic                              imem_rvalid,
    output logic                              imem_rready,
    input  core_pkg::inst_t                   imem_rdata,
    // Status and debug
    output logic [core_pkg::STATUS_W-1:0]     status,
    output core_pkg::xlen_t                   pc,
    output logic [32*core_pkg::XLEN-1:0]      dbg_regs
);

    inst_bus_if ibus ();
    reg_port_if rport ();

    //////////////////////////////////////////////////////////////////////
    // Controller
    //////////////////////////////////////////////////////////////////////

    core_control #(
        .BOOT_ADDR    (BOOT_ADDR),
        .RV32E        (RV32E)
    ) u_control (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .imem_arvalid (imem_arvalid),
        .imem_arready (imem_arready),
        .imem_araddr  (imem_araddr),
        .imem_rvalid  (imem_rvalid),
        .imem_rready  (imem_rready),
        .imem_rdata   (imem_rdata),
        .status       (status),
        .pc           (pc),
        .ibus         (ibus)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    alu_unit u_alu (
        .ibus         (ibus),
        .regs         (rport)
    );

    isa_registers #(
        .RV32E        (RV32E)
    ) u_regs (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .port         (rport),
        .dbg_regs     (dbg_regs)
    );

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the core testbench with Verilator, result taken from sim.log

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f src.f -o Vcore_tb \
    && ./obj_dir/Vcore_tb > sim.log 2>&1 \
    || echo "Done: errors found" >> sim.log
cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"

// File: src.f
rtl/core_pkg.sv
rtl/inst_bus_if.sv
rtl/reg_port_if.sv
rtl/inst_decoder.sv
rtl/isa_registers.sv
rtl/alu_unit.sv
rtl/core_control.sv
rtl/rv32i_core.sv
verif/clk_gen.sv
verif/core_properties.sv
verif/core_tb.sv

// File: verif/clk_gen.sv
/* Testbench clock and reset */

`timescale 1ns/1ns

module clk_gen (
    output logic aclk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Reset held for 16 cycles, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge aclk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// File: verif/core_properties.sv
/* Fetch channel assertions */

`timescale 1ns/1ns

module core_properties (
    input logic              aclk,
    input logic              rst_n,
    input logic              imem_arvalid,
    input logic              imem_arready,
    input core_pkg::xlen_t   imem_araddr,
    input logic              imem_rready,
    input logic [1:0]        state
);

    // Controller state encoding
    localparam logic [1:0] ST_HALT      = 2'd3;

    // A waiting request keeps its address
    a_addr_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        imem_arvalid && !imem_arready |=> imem_arvalid && $stable(imem_araddr))
        else $error("imem_araddr moved while a request was waiting");

    // Data phase opens only after an address transfer
    a_no_rready_in_req: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(imem_rready) |-> $past(imem_arvalid && imem_arready))
        else $error("imem_rready rose without an address transfer");

    a_quiet_in_halt: assert property (@(posedge aclk) disable iff (!rst_n)
        state == ST_HALT |-> !imem_arvalid)
        else $error("imem_arvalid high after the core halted");

endmodule

bind core_control core_properties u_props (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .imem_arvalid (imem_arvalid),
    .imem_arready (imem_arready),
    .imem_araddr  (imem_araddr),
    .imem_rready  (imem_rready),
    .state        (state)
);

// File: verif/core_tb.sv
/* RV32I core testbench */

`timescale 1ns/1ns

module core_tb;

    localparam core_pkg::xlen_t BOOT    = 32'h100;
    localparam int              N_ALU   = 60;
    localparam int              TIMEOUT = 200;

    typedef logic [31:0][core_pkg::XLEN-1:0] reg_file_t;

    logic                           aclk;
    logic                           rst_n;
    logic                           imem_arvalid;
    logic                           imem_arready;
    core_pkg::xlen_t                imem_araddr;
    logic                           imem_rvalid;
    logic                           imem_rready;
    core_pkg::inst_t                imem_rdata;
    logic [core_pkg::STATUS_W-1:0]  status;
    core_pkg::xlen_t                pc;
    reg_file_t                      dbg_regs;

    core_pkg::inst_t  imem [core_pkg::xlen_t];
    core_pkg::inst_t  exec_q [$];
    // MUL, SLLI with a bad funct7, ECALL
    core_pkg::inst_t  bad_words [3] = '{32'h0211_81b3, 32'h4020_9093, 32'h0000_0073};
    int               seed = 32'h153b8e93;
    int               errors = 0;
    int               n_words = 0;

    clk_gen u_clk (
        .aclk  (aclk),
        .rst_n (rst_n)
    );

    rv32i_core #(
        .BOOT_ADDR    (BOOT),
        .RV32E        (0)
    ) UUT (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .imem_arvalid (imem_arvalid),
        .imem_arready (imem_arready),
        .imem_araddr  (imem_araddr),
        .imem_rvalid  (imem_rvalid),
        .imem_rready  (imem_rready),
        .imem_rdata   (imem_rdata),
        .status       (status),
        .pc           (pc),
        .dbg_regs     (dbg_regs)
    );

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_xlen(input string name, input core_pkg::xlen_t got,
                              input core_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input logic [core_pkg::STATUS_W-1:0] got,
                                input logic [core_pkg::STATUS_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_state(input reg_file_t exp_regs,
                               input logic [core_pkg::STATUS_W-1:0] exp_status,
                               input core_pkg::xlen_t exp_pc);
        for (int i = 0; i < 32; i++) begin
            check_xlen($sformatf("dbg_regs[x%0d]", i), dbg_regs[i], exp_regs[i]);
        end
        check_status("status", status, exp_status);
        check_xlen("pc", pc, exp_pc);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic core_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                                input core_pkg::xlen_t a,
                                                input core_pkg::xlen_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        core_pkg::xlen_t    r;
        sa = a;
        sb = b;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = (sa < sb) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) r = sa >>> b[4:0];
                else     r = a >> b[4:0];
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic reg_file_t ref_exec(input core_pkg::inst_t w, input reg_file_t r_in,
                                           output logic [core_pkg::STATUS_W-1:0] st);
        reg_file_t        r;
        logic [6:0]       f7;
        logic [2:0]       f3;
        core_pkg::xlen_t  imm_i;
        logic             alt_ok;
        r      = r_in;
        st     = '0;
        f7     = w[31:25];
        f3     = w[14:12];
        imm_i  = {{20{w[31]}}, w[31:20]};
        // Bit 30 only selects SUB and SRA
        alt_ok = (f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101);
        case (w[6:0])
            core_pkg::OPC_OP: begin
                if (f7 == 7'h00 || alt_ok) begin
                    r[w[11:7]] = alu_ref(f3, f7[5], r_in[w[19:15]], r_in[w[24:20]]);
                end else begin
                    st[core_pkg::STATUS_ILLEGAL] = 1'b1;
                end
            end
            core_pkg::OPC_OP_IMM: begin
                if ((f3 == 3'b001 && f7 != 7'h00) ||
                    (f3 == 3'b101 && f7 != 7'h00 && !alt_ok)) begin
                    st[core_pkg::STATUS_ILLEGAL] = 1'b1;
                end else begin
                    r[w[11:7]] = alu_ref(f3, f3 == 3'b101 && f7[5], r_in[w[19:15]], imm_i);
                end
            end
            core_pkg::OPC_LUI: r[w[11:7]] = {w[31:12], 12'b0};
            default: begin
                if (w == core_pkg::EBREAK_WORD) st[core_pkg::STATUS_EBREAK] = 1'b1;
                else                            st[core_pkg::STATUS_ILLEGAL] = 1'b1;
            end
        endcase
        r[0] = '0;
        return r;
    endfunction

    // Random OP, OP_IMM or LUI word with a legal encoding
    function automatic core_pkg::inst_t random_alu_word();
        logic [2:0]   f3;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic         alt;
        logic [11:0]  imm12;
        int           kind;
        f3    = 3'($random(seed));
        rd    = 5'($random(seed));
        rs1   = 5'($random(seed));
        rs2   = 5'($random(seed));
        imm12 = 12'($random(seed));
        alt   = 1'($random(seed)) && (f3 == 3'b000 || f3 == 3'b101);
        kind  = $random(seed) & 7;
        if (kind < 3) begin
            return {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, core_pkg::OPC_OP};
        end
        if (kind < 6) begin
            if (f3 == 3'b001) imm12[11:5] = 7'h00;
            if (f3 == 3'b101) imm12[11:5] = alt ? 7'h20 : 7'h00;
            return {imm12, rs1, f3, rd, core_pkg::OPC_OP_IMM};
        end
        return {20'($random(seed)), rd, core_pkg::OPC_LUI};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Instruction memory with random latency
    //////////////////////////////////////////////////////////////////////

    initial begin : mem_model
        bit               ar_fire;
        bit               r_fire;
        bit               pending;
        int               delay;
        int               n_acc;
        core_pkg::xlen_t  addr;
        ar_fire      = 1'b0;
        r_fire       = 1'b0;
        pending      = 1'b0;
        delay        = 0;
        n_acc        = 0;
        addr         = '0;
        imem_arready = 1'b0;
        imem_rvalid  = 1'b0;
        imem_rdata   = '0;
        forever begin
            @(posedge aclk);
            #1;
            // Transfers taken on the edge just passed
            if (ar_fire) begin
                check_xlen("imem_araddr", addr, BOOT + 32'(4 * n_acc));
                n_acc++;
                pending = 1'b1;
                delay   = $random(seed) & 3;
            end
            if (r_fire) begin
                exec_q.push_back(imem_rdata);
                imem_rvalid = 1'b0;
            end
            imem_arready = ($random(seed) & 3) != 0;
            if (pending) begin
                if (delay == 0) begin
                    pending     = 1'b0;
                    imem_rvalid = 1'b1;
                    imem_rdata  = imem.exists(addr) ? imem[addr] : '0;
                    if (!imem.exists(addr)) begin
                        $display("Fetch from %h, which is outside the program", addr);
                        errors++;
                    end
                end else begin
                    delay--;
                end
            end
            ar_fire = imem_arvalid && imem_arready;
            r_fire  = imem_rvalid && imem_rready;
            if (ar_fire) addr = imem_araddr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Program, reset checks and per-instruction compare
    //////////////////////////////////////////////////////////////////////

    initial begin : main_seq
        reg_file_t                      exp_regs;
        logic [core_pkg::STATUS_W-1:0]  exp_status;
        logic [core_pkg::STATUS_W-1:0]  st;
        core_pkg::xlen_t                exp_pc;
        core_pkg::inst_t                w;
        bit                             ok;
        bit                             halted;
        bit                             late_req;
        int                             n;
        int                             n_exec;
        for (int i = 0; i < N_ALU; i++) begin
            if (i % 20 == 10) begin
                imem[BOOT + 32'(4 * n_words)] = bad_words[i / 20];
                n_words++;
            end
            w = random_alu_word();
            // Some results aimed at x0
            if (i % 9 == 4) w[11:7] = 5'd0;
            imem[BOOT + 32'(4 * n_words)] = w;
            n_words++;
        end
        imem[BOOT + 32'(4 * n_words)] = core_pkg::EBREAK_WORD;
        n_words++;

        ok = 1'b0;
        n  = 0;
        while (!ok && n < TIMEOUT) begin
            @(posedge aclk);
            #2;
            check_bit("imem_arvalid", imem_arvalid, 1'b0);
            check_bit("imem_rready", imem_rready, 1'b0);
            check_status("status", status, '0);
            check_xlen("pc", pc, BOOT);
            ok = rst_n;
            n++;
        end
        if (!ok) begin
            $display("Reset was never released");
            errors++;
        end

        exp_regs   = '0;
        exp_status = '0;
        exp_pc     = BOOT;
        halted     = 1'b0;
        n_exec     = 0;
        while (ok && !halted && n_exec < n_words) begin
            n = 0;
            while (exec_q.size() == 0 && n < TIMEOUT) begin
                @(posedge aclk);
                #2;
                n++;
            end
            if (exec_q.size() == 0) begin
                $display("No instruction arrived within %0d cycles, pc %h", TIMEOUT, pc);
                errors++;
                ok = 1'b0;
            end else begin
                w          = exec_q.pop_front();
                exp_regs   = ref_exec(w, exp_regs, st);
                exp_status = exp_status | st;
                halted     = st[core_pkg::STATUS_EBREAK];
                if (!halted) exp_pc = exp_pc + 32'd4;
                n_exec++;
                // Results land on the edge that closes EXEC
                @(posedge aclk);
                #2;
                check_state(exp_regs, exp_status, exp_pc);
            end
        end

        if (ok && !halted) begin
            $display("The core ran past the program without halting on EBREAK");
            errors++;
        end

        if (halted) begin
            late_req = 1'b0;
            for (n = 0; n < 100; n++) begin
                @(posedge aclk);
                #2;
                late_req = late_req | imem_arvalid;
            end
            if (late_req) begin
                $display("A fetch request appeared after EBREAK");
                errors++;
            end
            if (n_exec != n_words) begin
                $display("Executed %0d words, the program holds %0d", n_exec, n_words);
                errors++;
            end
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
